// File: files.f
logic/fp_misc_pkg.sv
logic/fp_classify.sv
logic/fp_compare_select.sv
logic/fp_issue_ctrl.sv
logic/fp_credit_counter.sv
logic/fp_misc_unit.sv
tb/fp_misc_unit_assert.sv
tb/tb_fp_misc_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fp_misc_unit -f files.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "All checks passed" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/tb_fp_misc_unit.sv
/*
 * Testbench for the FP misc unit. Sends compare, min/max, fclass and illegal
 * requests, models the consumer's credit returns and checks every response.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_fp_misc_unit import fp_misc_pkg::*; ();

   localparam int N_SPEC = 12; // special operand table
   localparam int N_RAND = 32; // random operands per op
   localparam int N_B2B  = 16;
   localparam int N_REQ  = 5 * (2 * N_SPEC + N_RAND) + N_SPEC + N_RAND + 26
                           + int'(CREDIT_MAX) + 2 + N_B2B;
   localparam int WATCHDOG_NS = (N_REQ * 10 + 200) * 40; // 10 cycles per request

   logic    clk = 1'b0;
   logic    rst_n;
   logic    req_valid;
   fp_req_t req;
   logic    req_ready;
   logic    rsp_valid;
   fp_rsp_t rsp;
   logic    credit_return;
   logic    hold_credit; // consumer keeps its slots
   fp_rsp_t exp_q[$];   // expected responses, request order
   fp_rsp_t expected;
   int      consumed = 0;
   int      returned = 0;
   int      checks = 0;
   int      check_errs = 0;
   int      flow_errs = 0;
   int      total_errs;

   fp_misc_unit u_dut (
      .clk             (clk),
      .rst_n_i         (rst_n),
      .req_valid_i     (req_valid),
      .req_i           (req),
      .req_ready_o     (req_ready),
      .rsp_valid_o     (rsp_valid),
      .rsp_o           (rsp),
      .credit_return_i (credit_return)
   );

   always #20 clk = ~clk; // 40 ns period

   function automatic logic [31:0] special(input int k);
      case (k)
         0:       return 32'h0000_0000; // +0
         1:       return 32'h8000_0000; // -0
         2:       return 32'h7f80_0000; // +inf
         3:       return 32'hff80_0000; // -inf
         4:       return 32'h7fc0_0000; // qnan
         5:       return 32'h7fa0_0000; // snan
         6:       return 32'h0000_0001; // smallest subnormal
         7:       return 32'h807f_ffff; // negative subnormal
         8:       return 32'h3f80_0000; // 1.0
         9:       return 32'hc040_0000; // -3.0
         10:      return 32'hffc0_0001; // negative qnan with payload
         default: return 32'h7f80_0001; // snan, low payload
      endcase
   endfunction

   function automatic logic [31:0] pick_operand();
      if ($urandom_range(1, 0) == 0)
         return special(int'($urandom_range(N_SPEC - 1, 0)));
      return $urandom();
   endfunction

   // riscv fclass bit from the raw encoding
   function automatic int unsigned class_bit(input logic [31:0] v);
      if (v[30:23] == 8'hff) begin
         if (v[22:0] == '0)
            return v[31] ? CLS_NINF : CLS_PINF;
         return v[22] ? CLS_QNAN : CLS_SNAN;
      end
      if (v[30:23] == 8'h00) begin
         if (v[22:0] == '0)
            return v[31] ? CLS_NZERO : CLS_PZERO;
         return v[31] ? CLS_NSUB : CLS_PSUB;
      end
      return v[31] ? CLS_NNORM : CLS_PNORM;
   endfunction

   // maps sign-magnitude onto unsigned order
   function automatic logic [31:0] order_key(input logic [31:0] v);
      return v[31] ? ~v : (v | 32'h8000_0000);
   endfunction

   function automatic fp_rsp_t model(input fp_req_t r);
      fp_rsp_t     e;
      logic [31:0] a;
      logic [31:0] b;
      int unsigned ca;
      int unsigned cb;
      logic        nan_a;
      logic        nan_b;
      logic        eq;
      logic        lt;
      e     = '0;
      a     = r.a;
      b     = r.b;
      ca    = class_bit(a);
      cb    = class_bit(b);
      nan_a = (ca >= CLS_SNAN);
      nan_b = (cb >= CLS_SNAN);
      eq    = !nan_a && !nan_b && (a == b || ((a | b) & 32'h7fff_ffff) == '0);
      lt    = !nan_a && !nan_b && !eq && (order_key(a) < order_key(b));
      case (r.op)
         OP_FEQ:    e.result.raw = {31'd0, eq};
         OP_FLT:    e.result.raw = {31'd0, lt};
         OP_FLE:    e.result.raw = {31'd0, lt | eq};
         OP_FMIN, OP_FMAX: begin
            if (ca == CLS_SNAN || cb == CLS_SNAN || (nan_a && nan_b))
               e.result.raw = NAN_CANON;
            else if (nan_a)
               e.result.raw = b;
            else if (nan_b)
               e.result.raw = a;
            else if (r.op == OP_FMIN)
               e.result.raw = (lt || eq) ? a : b;
            else
               e.result.raw = (lt || eq) ? b : a;
         end
         OP_FCLASS: e.result.raw = 32'd1 << ca;
         default:   e.illegal = 1'b1;
      endcase
      return e;
   endfunction

   // response check and expected-queue fill, sampled on the rising edge
   always @(posedge clk) begin
      if (rst_n && rsp_valid) begin
         consumed++;
         if (exp_q.size() == 0) begin
            check_errs++;
            $display("response at %0t ns with no request outstanding", $time);
         end else begin
            expected = exp_q.pop_front();
            checks++;
            assert (rsp == expected) else begin
               check_errs++;
               $display("** Error %0t ns: result %h illegal %b, expected %h illegal %b",
                        $time, rsp.result.raw, rsp.illegal, expected.result.raw,
                        expected.illegal);
            end
         end
      end
      if (rst_n && req_valid && req_ready)
         exp_q.push_back(model(req));
   end

   // falling edge step, consumer frees one slot per cycle unless held
   task automatic next_fall();
      @(negedge clk);
      credit_return = !hold_credit && (returned < consumed);
      if (credit_return)
         returned++;
   endtask

   task automatic send(input fp_op_e op, input logic [31:0] a, input logic [31:0] b);
      logic accepted;
      next_fall();
      req_valid = 1'b1;
      req.op    = op;
      req.a     = a;
      req.b     = b;
      accepted  = 1'b0;
      while (!accepted) begin
         @(posedge clk);
         accepted = req_ready;
         if (!accepted)
            next_fall();
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         next_fall();
         req_valid = 1'b0;
      end
   endtask

   task automatic finish_test(input string name);
      idle(1);
      while (exp_q.size() != 0 || returned != consumed)
         idle(1);
      $display("test %s done: %0d responses, %0d errors so far", name, checks,
               check_errs + flow_errs);
   endtask

   task automatic pair_test(input fp_op_e op);
      for (int i = 0; i < N_SPEC; i++) begin
         send(op, special(i), special((i + 1) % N_SPEC)); // covers +0 against -0
         send(op, special(i), special(i));                // equal pair
      end
      repeat (N_RAND)
         send(op, pick_operand(), pick_operand());
   endtask

   // 4 responses drain, then one held in each stage
   task automatic credit_stall_test();
      int base;
      hold_credit = 1'b1;
      base        = consumed;
      repeat (int'(CREDIT_MAX) + 2)
         send(OP_FMAX, pick_operand(), pick_operand());
      idle(6);
      assert (consumed - base == int'(CREDIT_MAX) && !req_ready) else begin
         flow_errs++;
         $display("** Error %0t ns: %0d responses without credit, ready %b", $time,
                  consumed - base, req_ready);
      end
      hold_credit = 1'b0;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before all requests completed");
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h0b40_f7e4)); // one seed for the run
      rst_n         = 1'b0;
      req_valid     = 1'b0;
      req           = '0;
      credit_return = 1'b0;
      hold_credit   = 1'b0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      pair_test(OP_FEQ);
      pair_test(OP_FLT);
      pair_test(OP_FLE);
      finish_test("compare");
      pair_test(OP_FMIN);
      pair_test(OP_FMAX);
      finish_test("fmin/fmax");
      for (int i = 0; i < N_SPEC + N_RAND; i++)
         send(OP_FCLASS, (i < N_SPEC) ? special(i) : $urandom(), 32'h0);
      finish_test("fclass");
      for (int v = 0; v < 32; v++) begin
         if (!(v inside {14, 15, 19, 20, 21, 22}))
            send(fp_op_e'(5'(v)), pick_operand(), pick_operand());
      end
      finish_test("illegal opcode");
      credit_stall_test();
      finish_test("credit stall");
      repeat (N_B2B)
         send(OP_FLT, pick_operand(), pick_operand()); // one per cycle
      finish_test("back-to-back");
      total_errs = check_errs + flow_errs + u_dut.u_protocol_assert.fail_cnt;
      $display("%0d responses checked, %0d errors", checks, total_errs);
      if (total_errs == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/fp_misc_unit_assert.sv
/*
 * Protocol checks for the FP misc unit, bound into its top level.
 * Covers credit use, reset state and the fixed two-cycle latency.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_misc_unit_assert import fp_misc_pkg::*; (
   input wire                clk,
   input wire                rst_n_i,
   input wire                req_valid_i,
   input wire                req_ready_i,
   input wire                rsp_valid_i,
   input wire                credit_avail_i,
   input wire [CREDIT_W-1:0] credit_cnt_i
);

   int   fail_cnt = 0; // summed into the testbench totals
   logic accept;

   assign accept = req_valid_i & req_ready_i; // request taken this edge

   rsp_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
      rsp_valid_i |-> credit_cnt_i != '0)
      else begin
         $error("response sent with no credit left");
         fail_cnt++;
      end

   credit_bounded: assert property (@(posedge clk) disable iff (!rst_n_i)
      credit_cnt_i <= CREDIT_MAX)
      else begin
         $error("credit count above buffer depth");
         fail_cnt++;
      end

   // first edge out of reset sees an idle, ready unit with full credit
   reset_state: assert property (@(posedge clk)
      $rose(rst_n_i) |-> !rsp_valid_i && req_ready_i && credit_cnt_i == CREDIT_MAX)
      else begin
         $error("unit not idle after reset");
         fail_cnt++;
      end

   // credit on both following edges gives the response two edges after accept
   fixed_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
      ($past(accept, 2) && $past(credit_avail_i) && credit_avail_i) |-> rsp_valid_i)
      else begin
         $error("response missing two cycles after accept");
         fail_cnt++;
      end

endmodule

bind fp_misc_unit fp_misc_unit_assert u_protocol_assert (
   .clk            (clk),
   .rst_n_i        (rst_n_i),
   .req_valid_i    (req_valid_i),
   .req_ready_i    (req_ready_o),
   .rsp_valid_i    (rsp_valid_o),
   .credit_avail_i (credit_avail),
   .credit_cnt_i   (u_credit_counter.credit_cnt)
);

`default_nettype wire

// File: logic/fp_misc_unit.sv
/*
 * Top of the FP misc unit: compares, min/max and fclass in a two-stage
 * pipeline with credit flow control on the response side.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_misc_unit import fp_misc_pkg::*; (
   input  wire     clk,
   input  wire     rst_n_i,
   // request side
   input  wire     req_valid_i,
   input  fp_req_t req_i,
   output logic    req_ready_o,
   // response side, no backpressure
   output logic    rsp_valid_o,
   output fp_rsp_t rsp_o,
   input  wire     credit_return_i // one pulse per freed slot
);

   logic      s1_load;
   logic      s2_load;
   logic      credit_avail;
   fp_stage_t stage;

   // stage 1 classify
   fp_classify u_classify (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .s1_load_i (s1_load),
      .req_i     (req_i),
      .stage_o   (stage)
   );

   // stage 2 result select
   fp_compare_select u_compare_select (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .s2_load_i (s2_load),
      .stage_i   (stage),
      .rsp_o     (rsp_o)
   );

   fp_issue_ctrl u_issue_ctrl (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .req_valid_i    (req_valid_i),
      .credit_avail_i (credit_avail),
      .req_ready_o    (req_ready_o),
      .s1_load_o      (s1_load),
      .s2_load_o      (s2_load),
      .rsp_valid_o    (rsp_valid_o)
   );

   // each response spends one credit
   fp_credit_counter u_credit_counter (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .consume_i       (rsp_valid_o),
      .credit_return_i (credit_return_i),
      .credit_avail_o  (credit_avail)
   );

endmodule

`default_nettype wire

// File: logic/fp_credit_counter.sv
/*
 * Credit counter for the downstream response buffer. Starts full,
 * drops on each response and rises on each returned credit.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_credit_counter import fp_misc_pkg::*; (
   input  wire  clk,
   input  wire  rst_n_i,
   input  wire  consume_i,       // response sent
   input  wire  credit_return_i, // consumer freed a slot
   output logic credit_avail_o
);

   logic [CREDIT_W-1:0] credit_cnt;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         credit_cnt <= CREDIT_MAX; // buffer empty after reset
      end else begin
         case ({consume_i, credit_return_i})
            2'b10: credit_cnt <= credit_cnt - CREDIT_W'(1);
            2'b01: begin
               if (credit_cnt != CREDIT_MAX)
                  credit_cnt <= credit_cnt + CREDIT_W'(1); // saturate at depth
            end
            default: credit_cnt <= credit_cnt; // none or both
         endcase
      end
   end

   assign credit_avail_o = |credit_cnt;

endmodule

`default_nettype wire

// File: logic/fp_issue_ctrl.sv
/*
 * Sequencer for the two pipeline stages. Tracks stage valids and a
 * small FSM, and derives loads, request ready and response valid.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_issue_ctrl import fp_misc_pkg::*; (
   input  wire  clk,
   input  wire  rst_n_i,
   input  wire  req_valid_i,
   input  wire  credit_avail_i, // downstream has room
   output logic req_ready_o,
   output logic s1_load_o,
   output logic s2_load_o,
   output logic rsp_valid_o
);

   issue_state_e state_q;
   issue_state_e state_d;
   logic         s1_valid_q;
   logic         s2_valid_q;
   logic         s1_valid_d;
   logic         s2_valid_d;
   logic         s2_drain; // response leaves this cycle
   logic         s2_free;  // stage 2 can take stage 1
   logic         s2_load;
   logic         s1_load;
   logic         req_ready;

   always_comb begin
      case (state_q)
         ST_EMPTY: begin
            s2_drain = 1'b0; // nothing to send
            s2_free  = 1'b1;
         end
         ST_STALL: begin
            s2_drain = credit_avail_i; // stage 2 is full here
            s2_free  = credit_avail_i;
         end
         default: begin
            s2_drain = s2_valid_q & credit_avail_i;
            s2_free  = ~s2_valid_q | credit_avail_i;
         end
      endcase
   end

   assign s2_load   = s1_valid_q & s2_free;
   assign req_ready = ~s1_valid_q | s2_load; // low only with both full and stuck
   assign s1_load   = req_valid_i & req_ready;

   assign s1_valid_d = s1_load | (s1_valid_q & ~s2_load);
   assign s2_valid_d = s2_load | (s2_valid_q & ~s2_drain);

   always_comb begin
      if (!s1_valid_d && !s2_valid_d)
         state_d = ST_EMPTY;
      else if (s2_valid_q && !credit_avail_i)
         state_d = ST_STALL; // held result, no credit yet
      else
         state_d = ST_FLOW;
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_EMPTY;
         s1_valid_q <= 1'b0;
         s2_valid_q <= 1'b0;
      end else begin
         state_q    <= state_d;
         s1_valid_q <= s1_valid_d;
         s2_valid_q <= s2_valid_d;
      end
   end

   assign req_ready_o = req_ready;
   assign s1_load_o   = s1_load;
   assign s2_load_o   = s2_load;
   assign rsp_valid_o = s2_drain;

endmodule

`default_nettype wire

// File: logic/fp_compare_select.sv
/*
 * Stage 2. Produces the compare, min/max or fclass result from the
 * classified operands and registers the response word on load.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_compare_select import fp_misc_pkg::*; (
   input  wire       clk,
   input  wire       rst_n_i,
   input  wire       s2_load_i, // capture a new response
   input  fp_stage_t stage_i,
   output fp_rsp_t   rsp_o
);

   fp32_t                  op_a;
   fp32_t                  op_b;
   fp_class_t              cls_a;
   fp_class_t              cls_b;
   logic [EXP_W+MAN_W-1:0] mag_a;
   logic [EXP_W+MAN_W-1:0] mag_b;
   logic                   any_nan;
   logic                   both_zero;
   logic                   is_eq;
   logic                   ord_lt;
   logic                   is_lt;
   logic                   pick_nan;
   fp32_t                  min_val;
   fp32_t                  max_val;
   fp_rsp_t                rsp_d;
   fp_rsp_t                rsp_q;

   assign op_a  = stage_i.req.a;
   assign op_b  = stage_i.req.b;
   assign cls_a = stage_i.class_a;
   assign cls_b = stage_i.class_b;
   assign mag_a = {op_a.exp, op_a.man}; // magnitude without sign
   assign mag_b = {op_b.exp, op_b.man};

   assign any_nan   = cls_a[CLS_SNAN] | cls_a[CLS_QNAN] | cls_b[CLS_SNAN] | cls_b[CLS_QNAN];
   assign both_zero = (cls_a[CLS_NZERO] | cls_a[CLS_PZERO]) &
                      (cls_b[CLS_NZERO] | cls_b[CLS_PZERO]); // +0 == -0

   assign is_eq = ~any_nan & ((op_a == op_b) | both_zero);

   // sign-magnitude ordering
   always_comb begin
      if (op_a.sign != op_b.sign)
         ord_lt = op_a.sign; // negative below positive
      else if (op_a.sign)
         ord_lt = mag_b < mag_a; // both negative, bigger magnitude is less
      else
         ord_lt = mag_a < mag_b;
   end

   assign is_lt = ~any_nan & ~is_eq & ord_lt;

   // fmin/fmax nan rules first, then ordering
   assign pick_nan = cls_a[CLS_SNAN] | cls_b[CLS_SNAN] | (cls_a[CLS_QNAN] & cls_b[CLS_QNAN]);

   always_comb begin
      if (pick_nan) begin
         min_val = NAN_CANON;
         max_val = NAN_CANON;
      end else if (cls_a[CLS_QNAN]) begin
         min_val = op_b; // only a is nan
         max_val = op_b;
      end else if (cls_b[CLS_QNAN]) begin
         min_val = op_a;
         max_val = op_a;
      end else begin
         min_val = (is_eq | is_lt) ? op_a : op_b; // equal gives a
         max_val = (is_eq | is_lt) ? op_b : op_a; // equal gives b
      end
   end

   always_comb begin
      rsp_d = '0;
      case (stage_i.req.op)
         OP_FMIN:   rsp_d.result.fp  = min_val;
         OP_FMAX:   rsp_d.result.fp  = max_val;
         OP_FEQ:    rsp_d.result.raw = {{(FP_W-1){1'b0}}, is_eq};
         OP_FLT:    rsp_d.result.raw = {{(FP_W-1){1'b0}}, is_lt};
         OP_FLE:    rsp_d.result.raw = {{(FP_W-1){1'b0}}, is_lt | is_eq};
         OP_FCLASS: rsp_d.result.raw = {{(FP_W-CLASS_W){1'b0}}, cls_a}; // rs1 only
         default:   rsp_d.illegal    = 1'b1; // zero result
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i)
         rsp_q <= '0;
      else if (s2_load_i)
         rsp_q <= rsp_d;
   end

   assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: logic/fp_classify.sv
/*
 * Stage 1. Decodes both operands into one-hot fclass masks and
 * registers them with the request when the sequencer loads the stage.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_classify import fp_misc_pkg::*; (
   input  wire       clk,
   input  wire       rst_n_i,
   input  wire       s1_load_i, // take a new request
   input  fp_req_t   req_i,
   output fp_stage_t stage_o
);

   fp_stage_t stage_q;
   fp_class_t class_a;
   fp_class_t class_b;

   function automatic fp_class_t classify_op(input fp32_t v);
      fp_class_t mask;
      logic      exp_max;
      logic      exp_zero;
      logic      man_zero;
      mask     = '0;
      exp_max  = &v.exp;  // inf or nan
      exp_zero = ~|v.exp; // zero or subnormal
      man_zero = ~|v.man;
      if (exp_max) begin
         if (man_zero)
            mask[v.sign ? CLS_NINF : CLS_PINF] = 1'b1;
         else if (v.man[MAN_W-1])
            mask[CLS_QNAN] = 1'b1; // quiet bit set
         else
            mask[CLS_SNAN] = 1'b1; // nonzero payload, quiet bit clear
      end else if (exp_zero) begin
         if (man_zero)
            mask[v.sign ? CLS_NZERO : CLS_PZERO] = 1'b1;
         else
            mask[v.sign ? CLS_NSUB : CLS_PSUB] = 1'b1;
      end else begin
         mask[v.sign ? CLS_NNORM : CLS_PNORM] = 1'b1;
      end
      return mask;
   endfunction

   assign class_a = classify_op(req_i.a);
   assign class_b = classify_op(req_i.b);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stage_q <= '0;
      end else if (s1_load_i) begin
         stage_q.req     <= req_i;
         stage_q.class_a <= class_a;
         stage_q.class_b <= class_b;
      end
   end

   assign stage_o = stage_q;

endmodule

`default_nettype wire

// File: logic/fp_misc_pkg.sv
/*
 * Shared widths, constants and types for the pipelined FP misc unit.
 * Import with a wildcard in the module header of every user.
 */
`default_nettype none

package fp_misc_pkg;

   // single precision field layout
   localparam int unsigned EXP_W   = 8;  // exponent bits
   localparam int unsigned MAN_W   = 23; // stored mantissa bits
   localparam int unsigned FP_W    = 32; // full word
   localparam int unsigned CLASS_W = 10; // fclass mask width

   localparam logic [FP_W-1:0] NAN_CANON = 32'h7fc0_0000; // canonical quiet nan

   // downstream buffer credits
   localparam int unsigned            CREDIT_W   = 3;
   localparam logic [CREDIT_W-1:0]    CREDIT_MAX = 3'd4; // buffer depth, reset value

   // fclass bit positions, riscv order
   localparam int unsigned CLS_NINF  = 0;
   localparam int unsigned CLS_NNORM = 1;
   localparam int unsigned CLS_NSUB  = 2;
   localparam int unsigned CLS_NZERO = 3;
   localparam int unsigned CLS_PZERO = 4;
   localparam int unsigned CLS_PSUB  = 5;
   localparam int unsigned CLS_PNORM = 6;
   localparam int unsigned CLS_PINF  = 7;
   localparam int unsigned CLS_SNAN  = 8;
   localparam int unsigned CLS_QNAN  = 9;

   // opcode numbering kept from the full fp block
   typedef enum logic [4:0] {
      OP_FMIN   = 5'd14,
      OP_FMAX   = 5'd15,
      OP_FEQ    = 5'd19,
      OP_FLT    = 5'd20,
      OP_FLE    = 5'd21,
      OP_FCLASS = 5'd22
   } fp_op_e;

   typedef struct packed {
      logic             sign;
      logic [EXP_W-1:0] exp;
      logic [MAN_W-1:0] man;
   } fp32_t;

   // result word, float for fmin/fmax, integer for compares and fclass
   typedef union packed {
      fp32_t           fp;
      logic [FP_W-1:0] raw;
   } fp_result_u;

   typedef struct packed {
      fp_op_e op;
      fp32_t  a; // rs1
      fp32_t  b; // rs2
   } fp_req_t;

   typedef logic [CLASS_W-1:0] fp_class_t; // one-hot class mask

   // stage 1 register contents
   typedef struct packed {
      fp_req_t   req;
      fp_class_t class_a;
      fp_class_t class_b;
   } fp_stage_t;

   typedef struct packed {
      fp_result_u result;
      logic       illegal; // opcode not supported here
   } fp_rsp_t;

   // pipeline sequencer states
   typedef enum logic [1:0] {
      ST_EMPTY, // nothing in flight
      ST_FLOW,  // items moving
      ST_STALL  // stage 2 held, no credit
   } issue_state_e;

endpackage

`default_nettype wire
